//--- design/nes_host_pkg.sv
package nes_host_pkg;

  // data byte from the ESP32 SPI link or the game loader
  typedef logic [7:0]  byte_t;

  // address as seen on the SPI RAM side of the ESP32 link
  typedef logic [31:0] spi_addr_t;

  // SDRAM byte address on port A
  typedef logic [21:0] mem_addr_t;

  // NES button order, MSB first: right left down up start select B A
  typedef logic [7:0]  buttons_t;

  // raw board buttons, bit 0 start (active low), then B A up down left right
  typedef logic [6:0]  board_btn_t;

  // USB decoder bits, [7:0] as buttons_t, bit 8 is reset
  typedef logic [8:0]  usb_btn_t;

  // NES clock-enable phase counter
  typedef logic [1:0]  nes_ce_t;

  // audio sample from the APU
  typedef logic [15:0] sample_t;

  // 4-bit DAC output to the audio jack
  typedef logic [3:0]  audio_t;

  // top address byte that selects the control register
  localparam logic [7:0] CTRL_PAGE = 8'hFF;

  // nes_ce value at which a staged loader write goes to SDRAM
  localparam nes_ce_t CE_WRITE_PHASE = 2'd3;

  // console reset hold after the download completes
  localparam logic [7:0] DOWNLOAD_HOLD = 8'd255;

  // low sample bits fed to the sigma-delta modulator
  localparam int DITHER_BITS = 12;

endpackage

//--- design/spi_ctrl_capture.sv
`timescale 1ns/1ns

module spi_ctrl_capture
(
  input  logic                  clock,
  input  logic                  i_reset,
  input  logic                  i_spi_wr,
  input  nes_host_pkg::spi_addr_t i_spi_addr,
  input  nes_host_pkg::byte_t   i_spi_data,
  output logic                  o_byte_strobe,
  output logic                  o_sys_reset
);

  logic spi_wr_q;  // i_spi_wr one cycle ago
  logic ctrl_q;    // control register bit 0, page FF
  logic ctrl_hit;

  // only the first cycle of a held i_spi_wr counts
  assign o_byte_strobe = i_spi_wr & ~spi_wr_q;

  assign ctrl_hit = i_spi_wr && (i_spi_addr[31:24] == nes_host_pkg::CTRL_PAGE);

  always_ff @(posedge clock)
  begin
    if (i_reset)
    begin
      spi_wr_q <= 1'b0;
      ctrl_q   <= 1'b0;
    end
    else
    begin
      spi_wr_q <= i_spi_wr;
      if (ctrl_hit)
      begin
        ctrl_q <= i_spi_data[0];  // reloads on every cycle of the write
      end
    end
  end

  assign o_sys_reset = ctrl_q;  // cpu reset from the ESP32

endmodule

//--- design/joypad_shifter.sv
`timescale 1ns/1ns

module joypad_shifter
(
  input  logic                     clock,
  input  logic                     i_reset,
  input  nes_host_pkg::board_btn_t i_btn,
  input  nes_host_pkg::usb_btn_t   i_usb_btn,
  input  logic                     i_joy_strobe,
  input  logic                     i_joy_clock,
  output logic                     o_joy_data
);

  nes_host_pkg::buttons_t board_map;
  nes_host_pkg::buttons_t board_q;      // board buttons, registered
  nes_host_pkg::buttons_t joy_bits;     // serial register read by the CPU
  logic                   joy_clock_q;
  logic                   joy_clock_fall;

  // no spare board button, so select stays 0
  assign board_map = {
    i_btn[6],   // right
    i_btn[5],   // left
    i_btn[4],   // down
    i_btn[3],   // up
    ~i_btn[0],  // start, active low on the board
    1'b0,       // select
    i_btn[1],   // B
    i_btn[2]    // A
  };

  assign joy_clock_fall = ~i_joy_clock & joy_clock_q;

  always_ff @(posedge clock)
  begin
    board_q <= board_map;
  end

  always_ff @(posedge clock)
  begin
    if (i_reset)
    begin
      joy_bits    <= '0;
      joy_clock_q <= 1'b0;
    end
    else
    begin
      joy_clock_q <= i_joy_clock;
      if (i_joy_strobe)
      begin
        joy_bits <= board_q | i_usb_btn[7:0];  // latch both sources
      end
      else if (joy_clock_fall)
      begin
        joy_bits <= {1'b0, joy_bits[7:1]};  // A comes out first
      end
    end
  end

  assign o_joy_data = joy_bits[0];

endmodule

//--- design/reset_sequencer.sv
`timescale 1ns/1ns

module reset_sequencer
(
  input  logic clock,
  input  logic i_reset,
  input  logic i_byte_strobe,
  input  logic i_load_done,
  input  logic i_sys_reset,
  output logic o_reset_nes
);

  logic       downloading;    // first SPI byte seen
  logic       init_reset;     // holds the console until a download starts
  logic [7:0] hold_cnt;       // post-download hold
  logic       download_reset;

  assign download_reset = (hold_cnt != 8'd0);

  always_ff @(posedge clock)
  begin
    if (i_reset)
    begin
      hold_cnt <= nes_host_pkg::DOWNLOAD_HOLD;
    end
    else if (!i_load_done)
    begin
      hold_cnt <= nes_host_pkg::DOWNLOAD_HOLD;  // rearm during every download
    end
    else if (download_reset)
    begin
      hold_cnt <= hold_cnt - 8'd1;
    end
  end

  // init_reset trails downloading by one cycle
  always_ff @(posedge clock)
  begin
    if (i_reset)
    begin
      downloading <= 1'b0;
      init_reset  <= 1'b1;
    end
    else
    begin
      if (!downloading && i_byte_strobe)
      begin
        downloading <= 1'b1;
      end
      if (downloading)
      begin
        init_reset <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (i_reset)
    begin
      o_reset_nes <= 1'b1;
    end
    else
    begin
      o_reset_nes <= !i_load_done || init_reset || download_reset || i_sys_reset;
    end
  end

endmodule

//--- design/sdram_port_a_select.sv
`timescale 1ns/1ns

module sdram_port_a_select
(
  input  logic                    clock,
  input  logic                    i_reset,
  input  logic                    i_load_done,
  input  nes_host_pkg::nes_ce_t   i_nes_ce,
  input  logic                    i_loader_write,
  input  nes_host_pkg::mem_addr_t i_loader_addr,
  input  nes_host_pkg::byte_t     i_loader_data,
  input  nes_host_pkg::mem_addr_t i_cpu_addr,
  input  logic                    i_cpu_write,
  input  nes_host_pkg::byte_t     i_cpu_dout,
  output nes_host_pkg::mem_addr_t o_mem_addr,
  output logic                    o_mem_we,
  output nes_host_pkg::byte_t     o_mem_din
);

  logic                    pending;      // loader write waiting for its phase
  logic                    loader_we;    // held for one nes_ce period
  nes_host_pkg::mem_addr_t loader_addr_q;
  nes_host_pkg::byte_t     loader_data_q;
  logic                    release_phase;

  assign release_phase = (i_nes_ce == nes_host_pkg::CE_WRITE_PHASE);

  // a later pulse overwrites a write that has not gone out yet
  always_ff @(posedge clock)
  begin
    if (i_loader_write)
    begin
      loader_addr_q <= i_loader_addr;
      loader_data_q <= i_loader_data;
    end
  end

  always_ff @(posedge clock)
  begin
    if (i_reset)
    begin
      pending   <= 1'b0;
      loader_we <= 1'b0;
    end
    else if (release_phase)
    begin
      // a pulse in the release cycle goes out with it
      loader_we <= pending | i_loader_write;
      pending   <= 1'b0;
    end
    else if (i_loader_write)
    begin
      pending <= 1'b1;
    end
  end

  // port A belongs to the loader until the download is done
  always_comb
  begin
    if (!i_load_done)
    begin
      o_mem_addr = loader_addr_q;
      o_mem_we   = loader_we;
      o_mem_din  = loader_data_q;
    end
    else
    begin
      o_mem_addr = i_cpu_addr;
      o_mem_we   = i_cpu_write;
      o_mem_din  = i_cpu_dout;
    end
  end

endmodule

//--- design/audio_dac.sv
`timescale 1ns/1ns

module audio_dac
(
  input  logic                  clock,
  input  logic                  i_reset_nes,
  input  nes_host_pkg::sample_t i_sample,
  output nes_host_pkg::audio_t  o_audio
);

  localparam int DW = nes_host_pkg::DITHER_BITS;
  localparam int SW = $bits(nes_host_pkg::sample_t);
  localparam int AW = $bits(nes_host_pkg::audio_t);

  logic [DW-1:0]        acc_q;       // first-order sigma-delta accumulator
  logic [DW:0]          acc_sum;
  logic                 dither_q;    // carry out, one cycle late
  nes_host_pkg::audio_t level_lo;
  nes_host_pkg::audio_t level_hi;

  // carry rate equals low bits / 2^DW, which fills in the missing resolution
  assign acc_sum = {1'b0, acc_q} + {1'b0, i_sample[DW-1:0]};

  always_ff @(posedge clock)
  begin
    if (i_reset_nes)
    begin
      acc_q    <= '0;
      dither_q <= 1'b0;
    end
    else
    begin
      acc_q    <= acc_sum[DW-1:0];
      dither_q <= acc_sum[DW];
    end
  end

  assign level_lo = i_sample[SW-1 -: AW];
  assign level_hi = level_lo + 4'd1;  // F wraps to 0

  assign o_audio = dither_q ? level_hi : level_lo;

endmodule

//--- design/nes_host_top.sv
`timescale 1ns/1ns

module nes_host_top
(
  input  logic                     clock,
  input  logic                     i_reset,
  input  logic                     i_spi_wr,
  input  nes_host_pkg::spi_addr_t  i_spi_addr,
  input  nes_host_pkg::byte_t      i_spi_data,
  input  nes_host_pkg::board_btn_t i_btn,
  input  nes_host_pkg::usb_btn_t   i_usb_btn,
  input  logic                     i_joy_strobe,
  input  logic                     i_joy_clock,
  input  logic                     i_load_done,
  input  logic                     i_loader_write,
  input  nes_host_pkg::mem_addr_t  i_loader_addr,
  input  nes_host_pkg::byte_t      i_loader_data,
  input  nes_host_pkg::nes_ce_t    i_nes_ce,
  input  nes_host_pkg::mem_addr_t  i_cpu_addr,
  input  logic                     i_cpu_write,
  input  nes_host_pkg::byte_t      i_cpu_dout,
  input  nes_host_pkg::sample_t    i_sample,
  output logic                     o_joy_data,
  output logic                     o_reset_nes,
  output nes_host_pkg::mem_addr_t  o_mem_addr,
  output logic                     o_mem_we,
  output nes_host_pkg::byte_t      o_mem_din,
  output nes_host_pkg::audio_t     o_audio
);

  logic byte_strobe;  // one pulse per SPI byte
  logic sys_reset;    // control register bit 0

  // input side
  spi_ctrl_capture i_spi_ctrl_capture
  (
    .clock         (clock),
    .i_reset       (i_reset),
    .i_spi_wr      (i_spi_wr),
    .i_spi_addr    (i_spi_addr),
    .i_spi_data    (i_spi_data),
    .o_byte_strobe (byte_strobe),
    .o_sys_reset   (sys_reset)
  );

  joypad_shifter i_joypad_shifter
  (
    .clock        (clock),
    .i_reset      (i_reset),
    .i_btn        (i_btn),
    .i_usb_btn    (i_usb_btn),
    .i_joy_strobe (i_joy_strobe),
    .i_joy_clock  (i_joy_clock),
    .o_joy_data   (o_joy_data)
  );

  // processing
  reset_sequencer i_reset_sequencer
  (
    .clock         (clock),
    .i_reset       (i_reset),
    .i_byte_strobe (byte_strobe),
    .i_load_done   (i_load_done),
    .i_sys_reset   (sys_reset),
    .o_reset_nes   (o_reset_nes)
  );

  sdram_port_a_select i_sdram_port_a_select
  (
    .clock          (clock),
    .i_reset        (i_reset),
    .i_load_done    (i_load_done),
    .i_nes_ce       (i_nes_ce),
    .i_loader_write (i_loader_write),
    .i_loader_addr  (i_loader_addr),
    .i_loader_data  (i_loader_data),
    .i_cpu_addr     (i_cpu_addr),
    .i_cpu_write    (i_cpu_write),
    .i_cpu_dout     (i_cpu_dout),
    .o_mem_addr     (o_mem_addr),
    .o_mem_we       (o_mem_we),
    .o_mem_din      (o_mem_din)
  );

  // output side, audio held quiet by the console reset
  audio_dac i_audio_dac
  (
    .clock       (clock),
    .i_reset_nes (o_reset_nes),
    .i_sample    (i_sample),
    .o_audio     (o_audio)
  );

endmodule

//--- tb/nes_host_props.sv
`timescale 1ns/1ns

module nes_host_props
(
  input logic                  clock,
  input logic                  i_reset,
  input logic                  i_load_done,
  input nes_host_pkg::nes_ce_t i_nes_ce,
  input logic                  o_reset_nes,
  input logic                  o_mem_we,
  input nes_host_pkg::audio_t  o_audio
);

  a_reset_nes_after_reset: assert property (@(posedge clock) i_reset |=> o_reset_nes)
    else $error("o_reset_nes low in the cycle after i_reset");

  // loader writes leave the stager only on the write phase
  a_we_on_phase: assert property (@(posedge clock) disable iff (i_reset)
    ($rose(o_mem_we) && !i_load_done && $past(!i_load_done))
      |-> ($past(i_nes_ce) == nes_host_pkg::CE_WRITE_PHASE))
    else $error("o_mem_we rose outside the nes_ce write phase");

  // dither bit is cleared one edge into a console reset
  a_audio_quiet: assert property (@(posedge clock) disable iff (i_reset)
    (o_reset_nes && $past(o_reset_nes) && $past(o_reset_nes, 2)) |-> $stable(o_audio))
    else $error("o_audio changed while the console was in reset");

endmodule

bind nes_host_top nes_host_props i_nes_host_props
(
  .clock       (clock),
  .i_reset     (i_reset),
  .i_load_done (i_load_done),
  .i_nes_ce    (i_nes_ce),
  .o_reset_nes (o_reset_nes),
  .o_mem_we    (o_mem_we),
  .o_audio     (o_audio)
);

//--- tb/tb_nes_host.sv
`timescale 1ns/1ns

module tb_nes_host;

  localparam int CLK_PERIOD    = 10;
  localparam int AUDIO_SAMPLES = 3;
  localparam int TEST_CYCLES   = 1100 + AUDIO_SAMPLES * 4100 + 300;
  localparam int WATCHDOG_NS   = 2 * TEST_CYCLES * CLK_PERIOD;

  logic                     clock;
  logic                     i_reset;
  logic                     i_spi_wr;
  nes_host_pkg::spi_addr_t  i_spi_addr;
  nes_host_pkg::byte_t      i_spi_data;
  nes_host_pkg::board_btn_t i_btn;
  nes_host_pkg::usb_btn_t   i_usb_btn;
  logic                     i_joy_strobe;
  logic                     i_joy_clock;
  logic                     i_load_done;
  logic                     i_loader_write;
  nes_host_pkg::mem_addr_t  i_loader_addr;
  nes_host_pkg::byte_t      i_loader_data;
  nes_host_pkg::nes_ce_t    i_nes_ce;
  nes_host_pkg::mem_addr_t  i_cpu_addr;
  logic                     i_cpu_write;
  nes_host_pkg::byte_t      i_cpu_dout;
  nes_host_pkg::sample_t    i_sample;
  logic                     o_joy_data;
  logic                     o_reset_nes;
  nes_host_pkg::mem_addr_t  o_mem_addr;
  logic                     o_mem_we;
  nes_host_pkg::byte_t      o_mem_din;
  nes_host_pkg::audio_t     o_audio;

  logic [31:0] lfsr;
  int          error_count;
  int          check_count;

  nes_host_top i_dut (.*);

  always #(CLK_PERIOD / 2) clock = ~clock;

  always @(posedge clock)
  begin
    #1 i_nes_ce <= i_nes_ce + 2'd1;  // free-running 0..3 like the core divider
  end

  // Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // board bit 0 is start (active low) and bits 1..6 are B A up down left right
  function automatic nes_host_pkg::buttons_t board_to_nes(input nes_host_pkg::board_btn_t b);
    return {b[6], b[5], b[4], b[3], ~b[0], 1'b0, b[1], b[2]};
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("ERR %0t %s got %0h expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("%0t %s", $time, what);
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic spi_write(input nes_host_pkg::spi_addr_t addr, input nes_host_pkg::byte_t data);
    i_spi_wr   = 1'b1;
    i_spi_addr = addr;
    i_spi_data = data;
    repeat (3) next_cycle();  // ESP32 holds the strobe for a few clocks
    i_spi_wr = 1'b0;
    repeat (2) next_cycle();
  endtask

  task automatic wait_reset_released(input int max_cycles);
    int n;
    n = 0;
    while (o_reset_nes && n < max_cycles)
    begin
      next_cycle();
      n++;
    end
    if (o_reset_nes)
      report_failure("o_reset_nes stayed high, the console never left reset");
  endtask

  task automatic test_reset_download();
    @(negedge clock);
    check("o_reset_nes", 32'(o_reset_nes), 32'd1);
    next_cycle();
    spi_write(32'h0000_1000, 8'h5A);
    i_load_done = 1'b1;
    for (int k = 1; k <= 256; k++)
    begin
      @(posedge clock);
      @(negedge clock);
      check("o_reset_nes", 32'(o_reset_nes), (k < 256) ? 32'd1 : 32'd0);
    end
    next_cycle();
    i_load_done = 1'b0;  // a new download
    repeat (2) next_cycle();
    check("o_reset_nes", 32'(o_reset_nes), 32'd1);
  endtask

  task automatic test_ctrl_register();
    i_load_done = 1'b1;
    wait_reset_released(300);
    spi_write({nes_host_pkg::CTRL_PAGE, 24'h000010}, 8'h01);
    check("o_reset_nes", 32'(o_reset_nes), 32'd1);
    spi_write({nes_host_pkg::CTRL_PAGE, 24'h000010}, 8'h02);
    check("o_reset_nes", 32'(o_reset_nes), 32'd0);
    spi_write(32'h1200_0010, 8'h01);  // not the control page
    repeat (4)
    begin
      next_cycle();
      check("o_reset_nes", 32'(o_reset_nes), 32'd0);
    end
  endtask

  task automatic test_loader_staging();
    nes_host_pkg::mem_addr_t addr;
    nes_host_pkg::byte_t     data;
    int                      waited;
    i_load_done = 1'b0;
    for (int p = 0; p < 8; p++)
    begin
      next_cycle();
      addr           = nes_host_pkg::mem_addr_t'(rand_bits(22));
      data           = nes_host_pkg::byte_t'(rand_bits(8));
      i_loader_write = 1'b1;
      i_loader_addr  = addr;
      i_loader_data  = data;
      next_cycle();
      i_loader_write = 1'b0;
      waited         = 1;
      @(negedge clock);
      while (!o_mem_we && waited < 5)
      begin
        @(negedge clock);
        waited++;
      end
      if (!o_mem_we)
        report_failure("o_mem_we did not rise within 5 cycles of a loader write");
      check("o_mem_addr", 32'(o_mem_addr), 32'(addr));
      check("o_mem_din", 32'(o_mem_din), 32'(data));
      repeat (3)
      begin
        @(negedge clock);
        check("o_mem_we", 32'(o_mem_we), 32'd1);
      end
      @(negedge clock);
      check("o_mem_we", 32'(o_mem_we), 32'd0);  // one nes_ce period only
      repeat (3) next_cycle();
    end
    i_load_done = 1'b1;  // CPU owns port A now
    repeat (4)
    begin
      next_cycle();
      i_cpu_addr  = nes_host_pkg::mem_addr_t'(rand_bits(22));
      i_cpu_dout  = nes_host_pkg::byte_t'(rand_bits(8));
      i_cpu_write = 1'(rand_bits(1));
      @(negedge clock);
      check("o_mem_addr", 32'(o_mem_addr), 32'(i_cpu_addr));
      check("o_mem_din", 32'(o_mem_din), 32'(i_cpu_dout));
      check("o_mem_we", 32'(o_mem_we), 32'(i_cpu_write));
    end
    next_cycle();
    i_cpu_write = 1'b0;
  endtask

  task automatic test_joypad();
    logic [8:0] expected;
    repeat (3)
    begin
      i_btn     = nes_host_pkg::board_btn_t'(rand_bits(7));
      i_usb_btn = nes_host_pkg::usb_btn_t'(rand_bits(9));
      expected  = {1'b0, board_to_nes(i_btn) | i_usb_btn[7:0]};
      next_cycle();
      i_joy_strobe = 1'b1;
      next_cycle();
      i_joy_strobe = 1'b0;
      next_cycle();
      for (int i = 0; i < 9; i++)
      begin
        check("o_joy_data", 32'(o_joy_data), 32'(expected[i]));
        i_joy_clock = 1'b1;
        next_cycle();
        i_joy_clock = 1'b0;  // falling edge shifts
        next_cycle();
      end
    end
  endtask

  task automatic test_audio();
    nes_host_pkg::audio_t top;
    logic [11:0]          low;
    int                   hi_count;
    i_load_done = 1'b1;
    wait_reset_released(300);
    repeat (AUDIO_SAMPLES)
    begin
      top      = 4'(rand_bits(4) % 15);  // keep top+1 from wrapping
      low      = 12'(rand_bits(12));
      i_sample = {top, low};
      hi_count = 0;
      next_cycle();  // dither of the previous sample
      repeat (4096)
      begin
        @(negedge clock);
        if (o_audio == top + 4'd1)
          hi_count++;
        else if (o_audio != top)
          report_failure("o_audio left the two levels around the sample");
      end
      check("o_audio high count", 32'(hi_count), 32'(low));
      next_cycle();
    end
    i_sample    = {4'h6, 12'hFFF};  // carries on nearly every cycle
    i_load_done = 1'b0;             // console back in reset
    repeat (3) next_cycle();
    repeat (8)
    begin
      @(negedge clock);
      check("o_audio", 32'(o_audio), 32'h6);  // dither held off
    end
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    clock          = 1'b0;
    lfsr           = 32'd89021;
    error_count    = 0;
    check_count    = 0;
    i_reset        = 1'b1;
    i_nes_ce       = '0;
    i_spi_wr       = 1'b0;
    i_spi_addr     = '0;
    i_spi_data     = '0;
    i_btn          = 7'b0000001;  // start released
    i_usb_btn      = '0;
    i_joy_strobe   = 1'b0;
    i_joy_clock    = 1'b0;
    i_load_done    = 1'b0;
    i_loader_write = 1'b0;
    i_loader_addr  = '0;
    i_loader_data  = '0;
    i_cpu_addr     = '0;
    i_cpu_write    = 1'b0;
    i_cpu_dout     = '0;
    i_sample       = '0;
    repeat (4) @(posedge clock);
    #1;
    i_reset = 1'b0;
    test_reset_download();
    test_ctrl_register();
    test_loader_staging();
    test_joypad();
    test_audio();
    repeat (4) next_cycle();
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- build.f
design/nes_host_pkg.sv
design/spi_ctrl_capture.sv
design/joypad_shifter.sv
design/reset_sequencer.sv
design/sdram_port_a_select.sv
design/audio_dac.sv
design/nes_host_top.sv
tb/nes_host_props.sv
tb/tb_nes_host.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, then look for the fail message in the log
verilator --binary --timing --assert --top-module tb_nes_host -f build.f -o sim_nes_host \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_nes_host > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q '>>> FAIL' sim.log && exit 1
grep -q '>>> PASS' sim.log || { echo "no verdict in sim.log"; exit 1; }
exit 0
